/* asp_host_shell.f */
logic/asp_shell_pkg.sv
logic/mmio_csr_router.sv
logic/irq_collector.sv
logic/host_wr_arbiter.sv
logic/asp_host_shell.sv
verif/asp_host_shell_props.sv
verif/asp_host_shell_tb.sv

/* logic/asp_host_shell.sv */
// ====================
// host shell top level with MMIO window routing, interrupt collection
// and host write sharing
// ====================
`timescale 1ns/1ns
`default_nettype none

module asp_host_shell (
    input  wire logic                           clk,
    input  wire logic                           reset,

    // host MMIO
    input  wire logic                           mmio_cyc,
    input  wire logic                           mmio_stb,
    input  wire logic                           mmio_we,
    input  wire asp_shell_pkg::mmio_word_addr_t mmio_adr,
    input  wire asp_shell_pkg::mmio_sel_t       mmio_sel,
    input  wire asp_shell_pkg::mmio_data_t      mmio_dat_w,
    output      asp_shell_pkg::mmio_data_t      mmio_dat_r,
    output      logic                           mmio_ack,

    // kernel control window
    output      logic                           cra_cyc,
    output      logic                           cra_stb,
    output      logic                           cra_we,
    output      asp_shell_pkg::csr_addr_t       cra_adr,
    output      asp_shell_pkg::mmio_sel_t       cra_sel,
    output      asp_shell_pkg::mmio_data_t      cra_dat_w,
    input  wire asp_shell_pkg::mmio_data_t      cra_dat_r,
    input  wire logic                           cra_ack,

    // DMA CSR window
    output      logic                           dma_csr_cyc,
    output      logic                           dma_csr_stb,
    output      logic                           dma_csr_we,
    output      asp_shell_pkg::csr_addr_t       dma_csr_adr,
    output      asp_shell_pkg::mmio_sel_t       dma_csr_sel,
    output      asp_shell_pkg::mmio_data_t      dma_csr_dat_w,
    input  wire asp_shell_pkg::mmio_data_t      dma_csr_dat_r,
    input  wire logic                           dma_csr_ack,

    // DMA engine host writes
    input  wire logic                           dma_wr_cyc,
    input  wire logic                           dma_wr_stb,
    input  wire asp_shell_pkg::host_byte_addr_t dma_wr_adr,
    input  wire asp_shell_pkg::host_data_t      dma_wr_dat,
    input  wire asp_shell_pkg::host_sel_t       dma_wr_sel,
    output      logic                           dma_wr_ack,

    // host memory writes
    output      logic                           host_wr_cyc,
    output      logic                           host_wr_stb,
    output      asp_shell_pkg::host_line_addr_t host_wr_adr,
    output      asp_shell_pkg::host_data_t      host_wr_dat,
    output      asp_shell_pkg::host_sel_t       host_wr_sel,
    input  wire logic                           host_wr_ack,

    // interrupts and fence
    input  wire logic                           kernel_irq,
    input  wire logic                           dma_irq_h2f,
    input  wire logic                           dma_irq_f2h,
    input  wire logic                           dma_wr_fence
);

    asp_shell_pkg::irq_vec_t irq_vec;
    logic                    notify_req;
    logic                    notify_done;

    mmio_csr_router mmio_csr_router_i (
        .mmio_cyc, .mmio_stb, .mmio_we, .mmio_adr, .mmio_sel, .mmio_dat_w,
        .mmio_dat_r, .mmio_ack,
        .cra_cyc, .cra_stb, .cra_we, .cra_adr, .cra_sel, .cra_dat_w,
        .cra_dat_r, .cra_ack,
        .dma_csr_cyc, .dma_csr_stb, .dma_csr_we, .dma_csr_adr, .dma_csr_sel,
        .dma_csr_dat_w, .dma_csr_dat_r, .dma_csr_ack
    );

    irq_collector irq_collector_i (
        .clk,
        .reset,
        .kernel_irq,
        .dma_irq_h2f,
        .dma_irq_f2h,
        .notify_done,
        .irq_vec,
        .notify_req
    );

    host_wr_arbiter host_wr_arbiter_i (
        .clk,
        .reset,
        .dma_wr_cyc,
        .dma_wr_stb,
        .dma_wr_fence,
        .dma_wr_adr,
        .dma_wr_dat,
        .dma_wr_sel,
        .dma_wr_ack,
        .irq_vec,       // sampled when the notification is granted
        .notify_req,
        .notify_done,
        .host_wr_cyc,
        .host_wr_stb,
        .host_wr_adr,
        .host_wr_dat,
        .host_wr_sel,
        .host_wr_ack
    );

endmodule : asp_host_shell

`default_nettype wire

/* logic/asp_shell_pkg.sv */
// ====================
// widths, vector types and fixed constants shared by the host shell blocks
// ====================
`default_nettype none

package asp_shell_pkg;

    // host MMIO with 64-bit words
    localparam int MMIO_WORD_ADDR_W = 15;
    localparam int CSR_BYTE_ADDR_W  = 17;   // byte address inside one CSR window
    localparam int MMIO_DATA_W      = 64;

    typedef logic [MMIO_WORD_ADDR_W-1:0] mmio_word_addr_t;
    typedef logic [CSR_BYTE_ADDR_W-1:0]  csr_addr_t;
    typedef logic [MMIO_DATA_W-1:0]      mmio_data_t;
    typedef logic [MMIO_DATA_W/8-1:0]    mmio_sel_t;

    localparam mmio_sel_t UPPER_HALF_SEL = 8'hF0;  // 32-bit access to the upper half

    // host memory writes
    localparam int HOST_BYTE_ADDR_W = 48;
    localparam int LINE_OFFSET_W    = 6;    // 64-byte lines
    localparam int HOST_DATA_W      = 512;

    typedef logic [HOST_BYTE_ADDR_W-1:0]               host_byte_addr_t;
    typedef logic [HOST_BYTE_ADDR_W-LINE_OFFSET_W-1:0] host_line_addr_t;
    typedef logic [HOST_DATA_W-1:0]                    host_data_t;
    typedef logic [HOST_DATA_W/8-1:0]                  host_sel_t;

    // interrupt vector layout
    localparam int IRQ_LINES       = 4;
    localparam int KERNEL_IRQ_BIT  = 0;
    localparam int DMA_H2F_IRQ_BIT = 1;
    localparam int DMA_F2H_IRQ_BIT = 2;
    localparam int IRQ_SYNC_STAGES = 3;

    typedef logic [IRQ_LINES-1:0] irq_vec_t;

    // host line that receives the interrupt vector
    localparam host_line_addr_t IRQ_STATUS_LINE = 42'h3FF_0000;

    // owner of the host write port
    typedef enum logic [1:0] {
        idle,
        dma,
        notify
    } wr_owner_e;

endpackage : asp_shell_pkg

`default_nettype wire

/* logic/host_wr_arbiter.sv */
// ====================
// host write port shared by DMA line writes and interrupt status writes
// ====================
`timescale 1ns/1ns
`default_nettype none

module host_wr_arbiter (
    input  wire logic                           clk,
    input  wire logic                           reset,

    // DMA engine writes, byte addressed
    input  wire logic                           dma_wr_cyc,
    input  wire logic                           dma_wr_stb,
    input  wire logic                           dma_wr_fence,
    input  wire asp_shell_pkg::host_byte_addr_t dma_wr_adr,
    input  wire asp_shell_pkg::host_data_t      dma_wr_dat,
    input  wire asp_shell_pkg::host_sel_t       dma_wr_sel,
    output      logic                           dma_wr_ack,

    // interrupt notification
    input  wire asp_shell_pkg::irq_vec_t        irq_vec,
    input  wire logic                           notify_req,
    output      logic                           notify_done,

    // host memory, line addressed
    output      logic                           host_wr_cyc,
    output      logic                           host_wr_stb,
    output      asp_shell_pkg::host_line_addr_t host_wr_adr,
    output      asp_shell_pkg::host_data_t      host_wr_dat,
    output      asp_shell_pkg::host_sel_t       host_wr_sel,
    input  wire logic                           host_wr_ack
);

    asp_shell_pkg::wr_owner_e state;
    asp_shell_pkg::irq_vec_t  notify_vec;   // vector as sampled at grant
    logic                     in_dma;
    logic                     in_notify;

    assign in_dma    = (state == asp_shell_pkg::dma);
    assign in_notify = (state == asp_shell_pkg::notify);

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= asp_shell_pkg::idle;
        end else begin
            case (state)
                asp_shell_pkg::idle: begin
                    // notification first, but never past an open fence
                    if (notify_req && !dma_wr_fence) begin
                        state <= asp_shell_pkg::notify;
                    end else if (dma_wr_cyc && dma_wr_stb) begin
                        state <= asp_shell_pkg::dma;
                    end
                end
                asp_shell_pkg::dma: begin
                    if (host_wr_ack || !dma_wr_cyc) begin  // done, or master gave up
                        state <= asp_shell_pkg::idle;
                    end
                end
                asp_shell_pkg::notify: begin
                    if (host_wr_ack) begin
                        state <= asp_shell_pkg::idle;
                    end
                end
                default: state <= asp_shell_pkg::idle;
            endcase
        end
    end

    // capture the vector as the notification is granted
    always_ff @(posedge clk) begin
        if (state == asp_shell_pkg::idle && notify_req && !dma_wr_fence) begin
            notify_vec <= irq_vec;
        end
    end

    // host side request mux
    always_comb begin
        if (in_notify) begin
            host_wr_cyc = 1'b1;
            host_wr_stb = 1'b1;
            host_wr_adr = asp_shell_pkg::IRQ_STATUS_LINE;
            host_wr_dat = asp_shell_pkg::host_data_t'(notify_vec);  // zero-extended
            host_wr_sel = '1;
        end else begin
            host_wr_cyc = in_dma & dma_wr_cyc;
            host_wr_stb = in_dma & dma_wr_stb;
            host_wr_adr = dma_wr_adr[asp_shell_pkg::HOST_BYTE_ADDR_W-1:
                                     asp_shell_pkg::LINE_OFFSET_W];  // byte to line
            host_wr_dat = dma_wr_dat;
            host_wr_sel = dma_wr_sel;
        end
    end

    // acks route back to whoever owns the port
    assign dma_wr_ack  = in_dma & host_wr_ack;
    assign notify_done = in_notify & host_wr_ack;

endmodule : host_wr_arbiter

`default_nettype wire

/* logic/irq_collector.sv */
// ====================
// gathers kernel and DMA interrupts into one vector, flags new ones for notification
// ====================
`timescale 1ns/1ns
`default_nettype none

module irq_collector (
    input  wire logic                    clk,
    input  wire logic                    reset,
    input  wire logic                    kernel_irq,    // async, kernel clock domain
    input  wire logic                    dma_irq_h2f,
    input  wire logic                    dma_irq_f2h,
    input  wire logic                    notify_done,
    output      asp_shell_pkg::irq_vec_t irq_vec,
    output      logic                    notify_req
);

    // first synchronizer stages; the vector register is the last one
    logic [asp_shell_pkg::IRQ_SYNC_STAGES-2:0] kirq_meta;
    asp_shell_pkg::irq_vec_t                   vec_next;
    asp_shell_pkg::irq_vec_t                   vec_prev;
    logic                                      irq_rise;

    always_ff @(posedge clk) begin
        if (reset) begin
            kirq_meta <= '0;
        end else begin
            kirq_meta <= {kirq_meta[asp_shell_pkg::IRQ_SYNC_STAGES-3:0], kernel_irq};
        end
    end

    always_comb begin
        vec_next = '0;  // spare line stays low
        vec_next[asp_shell_pkg::KERNEL_IRQ_BIT]  =
            kirq_meta[asp_shell_pkg::IRQ_SYNC_STAGES-2];
        vec_next[asp_shell_pkg::DMA_H2F_IRQ_BIT] = dma_irq_h2f;
        vec_next[asp_shell_pkg::DMA_F2H_IRQ_BIT] = dma_irq_f2h;
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            irq_vec  <= '0;
            vec_prev <= '0;
        end else begin
            irq_vec  <= vec_next;
            vec_prev <= irq_vec;
        end
    end

    // any line going high since last cycle
    assign irq_rise = |(irq_vec & ~vec_prev);

    // a fresh edge beats the done pulse
    always_ff @(posedge clk) begin
        if (reset) begin
            notify_req <= 1'b0;
        end else if (irq_rise) begin
            notify_req <= 1'b1;
        end else if (notify_done) begin
            notify_req <= 1'b0;
        end
    end

endmodule : irq_collector

`default_nettype wire

/* logic/mmio_csr_router.sv */
// ====================
// splits host MMIO into the kernel control and DMA CSR windows
// ====================
`timescale 1ns/1ns
`default_nettype none

module mmio_csr_router (
    // host MMIO slave
    input  wire logic                           mmio_cyc,
    input  wire logic                           mmio_stb,
    input  wire logic                           mmio_we,
    input  wire asp_shell_pkg::mmio_word_addr_t mmio_adr,
    input  wire asp_shell_pkg::mmio_sel_t       mmio_sel,
    input  wire asp_shell_pkg::mmio_data_t      mmio_dat_w,
    output      asp_shell_pkg::mmio_data_t      mmio_dat_r,
    output      logic                           mmio_ack,

    // kernel control window
    output      logic                           cra_cyc,
    output      logic                           cra_stb,
    output      logic                           cra_we,
    output      asp_shell_pkg::csr_addr_t       cra_adr,
    output      asp_shell_pkg::mmio_sel_t       cra_sel,
    output      asp_shell_pkg::mmio_data_t      cra_dat_w,
    input  wire asp_shell_pkg::mmio_data_t      cra_dat_r,
    input  wire logic                           cra_ack,

    // DMA controller CSR window
    output      logic                           dma_csr_cyc,
    output      logic                           dma_csr_stb,
    output      logic                           dma_csr_we,
    output      asp_shell_pkg::csr_addr_t       dma_csr_adr,
    output      asp_shell_pkg::mmio_sel_t       dma_csr_sel,
    output      asp_shell_pkg::mmio_data_t      dma_csr_dat_w,
    input  wire asp_shell_pkg::mmio_data_t      dma_csr_dat_r,
    input  wire logic                           dma_csr_ack
);

    logic [asp_shell_pkg::CSR_BYTE_ADDR_W:0] byte_adr;  // 18-bit byte address
    logic                                    dma_hit;

    // word address on [17:3], upper-half flag on [2], [1:0] always zero
    assign byte_adr = {mmio_adr, (mmio_sel == asp_shell_pkg::UPPER_HALF_SEL), 2'b00};
    assign dma_hit  = byte_adr[asp_shell_pkg::CSR_BYTE_ADDR_W];

    // only the addressed window sees the cycle
    assign cra_cyc     = mmio_cyc & ~dma_hit;
    assign cra_stb     = mmio_stb & ~dma_hit;
    assign dma_csr_cyc = mmio_cyc & dma_hit;
    assign dma_csr_stb = mmio_stb & dma_hit;

    // shared request fields with the window bit dropped
    assign cra_we        = mmio_we;
    assign cra_adr       = byte_adr[asp_shell_pkg::CSR_BYTE_ADDR_W-1:0];
    assign cra_sel       = mmio_sel;
    assign cra_dat_w     = mmio_dat_w;
    assign dma_csr_we    = mmio_we;
    assign dma_csr_adr   = byte_adr[asp_shell_pkg::CSR_BYTE_ADDR_W-1:0];
    assign dma_csr_sel   = mmio_sel;
    assign dma_csr_dat_w = mmio_dat_w;

    // response from the selected window in the same cycle
    always_comb begin
        if (dma_hit) begin
            mmio_dat_r = dma_csr_dat_r;
            mmio_ack   = mmio_cyc & mmio_stb & dma_csr_ack;
        end else begin
            mmio_dat_r = cra_dat_r;
            mmio_ack   = mmio_cyc & mmio_stb & cra_ack;
        end
    end

endmodule : mmio_csr_router

`default_nettype wire

/* run_sim.sh */
#!/bin/sh
# build and run the host shell testbench with Verilator
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert \
    --top-module asp_host_shell_tb \
    -f asp_host_shell.f \
    -o asp_host_shell_sim

./obj_dir/asp_host_shell_sim | tee sim.log

if grep -qx "sim passed" sim.log; then
    echo "run_sim: PASS"
    exit 0
else
    echo "run_sim: FAIL"
    exit 1
fi

/* verif/asp_host_shell_props.sv */
// ====================
// Wishbone handshake checks on the host shell ports, bound onto the top level
// ====================
`timescale 1ns/1ns
`default_nettype none

module asp_host_shell_props (
    input wire logic                           clk,
    input wire logic                           reset,
    input wire logic                           mmio_stb,
    input wire logic                           mmio_ack,
    input wire logic                           cra_cyc,
    input wire logic                           cra_stb,
    input wire logic                           cra_ack,
    input wire logic                           dma_csr_cyc,
    input wire logic                           dma_csr_stb,
    input wire logic                           dma_csr_ack,
    input wire logic                           dma_wr_stb,
    input wire logic                           dma_wr_ack,
    input wire logic                           host_wr_cyc,
    input wire logic                           host_wr_stb,
    input wire logic                           host_wr_ack,
    input wire asp_shell_pkg::host_line_addr_t host_wr_adr
);

    // each request stays up until its ack
    mmio_held: assert property (@(posedge clk) disable iff (reset)
        mmio_stb && !mmio_ack |=> mmio_stb) else $error("mmio_stb dropped before ack");
    cra_held: assert property (@(posedge clk) disable iff (reset)
        cra_stb && !cra_ack |=> cra_stb) else $error("cra_stb dropped before ack");
    csr_held: assert property (@(posedge clk) disable iff (reset)
        dma_csr_stb && !dma_csr_ack |=> dma_csr_stb)
        else $error("dma_csr_stb dropped before ack");
    dma_wr_held: assert property (@(posedge clk) disable iff (reset)
        dma_wr_stb && !dma_wr_ack |=> dma_wr_stb) else $error("dma_wr_stb dropped before ack");
    host_held: assert property (@(posedge clk) disable iff (reset)
        host_wr_stb && !host_wr_ack |=> host_wr_stb) else $error("host_wr_stb dropped before ack");

    // line address frozen while the host keeps us waiting
    host_adr_stable: assert property (@(posedge clk) disable iff (reset)
        host_wr_stb && !host_wr_ack |=> $stable(host_wr_adr))
        else $error("host_wr_adr changed while waiting for ack");

    // one CSR window at a time
    one_window: assert property (@(posedge clk) !(cra_stb && dma_csr_stb))
        else $error("cra_stb and dma_csr_stb high together");

    quiet_in_reset: assert property (@(posedge clk)
        reset |-> !cra_cyc && !dma_csr_cyc && !host_wr_cyc)
        else $error("cyc output high during reset");

endmodule : asp_host_shell_props

bind asp_host_shell asp_host_shell_props props_i (.*);

`default_nettype wire

/* verif/asp_host_shell_tb.sv */
// ====================
// directed tests for the host shell with CSR and host memory responders
// ====================
`timescale 1ns/1ns
`default_nettype none

module asp_host_shell_tb;

    localparam int MAX_CYCLES = 2000;  // tests take about 400

    logic                           clk;
    logic                           reset;
    logic                           mmio_cyc, mmio_stb, mmio_we, mmio_ack;
    asp_shell_pkg::mmio_word_addr_t mmio_adr;
    asp_shell_pkg::mmio_sel_t       mmio_sel;
    asp_shell_pkg::mmio_data_t      mmio_dat_w, mmio_dat_r;
    logic                           cra_cyc, cra_stb, cra_we;
    asp_shell_pkg::csr_addr_t       cra_adr;
    asp_shell_pkg::mmio_sel_t       cra_sel;
    asp_shell_pkg::mmio_data_t      cra_dat_w;
    asp_shell_pkg::mmio_data_t      cra_dat_r = '0;
    logic                           cra_ack = 1'b0;
    logic                           dma_csr_cyc, dma_csr_stb, dma_csr_we;
    asp_shell_pkg::csr_addr_t       dma_csr_adr;
    asp_shell_pkg::mmio_sel_t       dma_csr_sel;
    asp_shell_pkg::mmio_data_t      dma_csr_dat_w;
    asp_shell_pkg::mmio_data_t      dma_csr_dat_r = '0;
    logic                           dma_csr_ack = 1'b0;
    logic                           dma_wr_cyc, dma_wr_stb, dma_wr_ack;
    asp_shell_pkg::host_byte_addr_t dma_wr_adr;
    asp_shell_pkg::host_data_t      dma_wr_dat;
    asp_shell_pkg::host_sel_t       dma_wr_sel;
    logic                           host_wr_cyc, host_wr_stb;
    asp_shell_pkg::host_line_addr_t host_wr_adr;
    asp_shell_pkg::host_data_t      host_wr_dat;
    asp_shell_pkg::host_sel_t       host_wr_sel;
    logic                           host_wr_ack = 1'b0;
    logic                           kernel_irq, dma_irq_h2f, dma_irq_f2h, dma_wr_fence;

    int error_count = 0;
    int test_count  = 0;
    int cycle_count = 0;
    asp_shell_pkg::host_line_addr_t wr_adr_q[$];  // every write the host accepted
    asp_shell_pkg::host_data_t      wr_dat_q[$];
    asp_shell_pkg::host_sel_t       wr_sel_q[$];

    asp_host_shell dut_i (.*);

    always #50 clk = ~clk;

    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count >= MAX_CYCLES) begin
            $display("timeout: tests did not finish within %0d cycles", MAX_CYCLES);
            $display("sim failed");
            $finish;
        end
    end

    // slaves sample mid-cycle and ack 0 to 3 cycles later
    always begin
        @(negedge clk);
        if (cra_cyc && cra_stb) begin
            repeat ($urandom % 4) @(posedge clk);
            @(posedge clk);
            #1;
            cra_dat_r = {$urandom, $urandom};
            cra_ack   = 1'b1;
            @(posedge clk);
            #1 cra_ack = 1'b0;
        end
    end

    always begin
        @(negedge clk);
        if (dma_csr_cyc && dma_csr_stb) begin
            repeat ($urandom % 4) @(posedge clk);
            @(posedge clk);
            #1;
            dma_csr_dat_r = {$urandom, $urandom};
            dma_csr_ack   = 1'b1;
            @(posedge clk);
            #1 dma_csr_ack = 1'b0;
        end
    end

    always begin
        @(negedge clk);
        if (host_wr_cyc && host_wr_stb) begin
            wr_adr_q.push_back(host_wr_adr);  // held stable until ack
            wr_dat_q.push_back(host_wr_dat);
            wr_sel_q.push_back(host_wr_sel);
            repeat ($urandom % 4) @(posedge clk);
            @(posedge clk);
            #1 host_wr_ack = 1'b1;
            @(posedge clk);
            #1 host_wr_ack = 1'b0;
        end
    end

    task automatic drive_slot;
        @(posedge clk);
        #1;
    endtask

    task automatic report_mismatch(input string what);
        error_count++;
        $display("Mismatch at %0t ns: %s", $time, what);
    endtask

    task automatic check_reset_state;
        test_count++;
        @(negedge clk);
        if (cra_cyc || cra_stb || dma_csr_cyc || dma_csr_stb || host_wr_cyc || host_wr_stb
                || mmio_ack)
            report_mismatch("bus signal high right after reset");
    endtask

    task automatic mmio_access(input logic we, input asp_shell_pkg::mmio_word_addr_t adr,
                               input asp_shell_pkg::mmio_sel_t sel,
                               input asp_shell_pkg::mmio_data_t wdata);
        logic [17:0]               exp_byte;
        logic                      to_dma;
        logic                      done;
        logic                      hit_stb;
        logic                      hit_ack;
        logic                      other_busy;
        asp_shell_pkg::csr_addr_t  hit_adr;
        asp_shell_pkg::mmio_data_t resp_dat;
        test_count++;
        exp_byte = {adr, sel == 8'hF0, 2'b00};  // bit 2 flags the upper half
        to_dma   = exp_byte[17];
        done     = 1'b0;
        drive_slot();
        mmio_cyc   = 1'b1;
        mmio_stb   = 1'b1;
        mmio_we    = we;
        mmio_adr   = adr;
        mmio_sel   = sel;
        mmio_dat_w = wdata;
        while (!done) begin
            @(negedge clk);
            hit_stb    = to_dma ? (dma_csr_cyc && dma_csr_stb) : (cra_cyc && cra_stb);
            hit_ack    = to_dma ? dma_csr_ack : cra_ack;
            other_busy = to_dma ? (cra_cyc || cra_stb) : (dma_csr_cyc || dma_csr_stb);
            hit_adr    = to_dma ? dma_csr_adr : cra_adr;
            resp_dat   = to_dma ? dma_csr_dat_r : cra_dat_r;
            if (!hit_stb || other_busy)
                report_mismatch($sformatf("wrong window for word %h, dma %b", adr, to_dma));
            if (hit_adr !== exp_byte[16:0])
                report_mismatch($sformatf("csr adr %h expected %h", hit_adr, exp_byte[16:0]));
            if ((to_dma ? dma_csr_we : cra_we) !== we
                    || (to_dma ? dma_csr_sel : cra_sel) !== sel)
                report_mismatch($sformatf("we/sel not passed through for word %h", adr));
            if ((to_dma ? dma_csr_dat_w : cra_dat_w) !== wdata)
                report_mismatch($sformatf("write data changed for word %h", adr));
            if (mmio_ack !== hit_ack)
                report_mismatch($sformatf("mmio_ack %b with window ack %b", mmio_ack, hit_ack));
            if (mmio_ack) begin
                if (!we && mmio_dat_r !== resp_dat)
                    report_mismatch($sformatf("read %h expected %h", mmio_dat_r, resp_dat));
                done = 1'b1;
            end
        end
        drive_slot();
        mmio_cyc = 1'b0;
        mmio_stb = 1'b0;
        mmio_we  = 1'b0;
    endtask

    task automatic dma_write(input asp_shell_pkg::host_byte_addr_t adr,
                             input asp_shell_pkg::host_data_t dat,
                             input asp_shell_pkg::host_sel_t sel);
        int   n_before;
        logic done;
        test_count++;
        n_before = wr_adr_q.size();
        done     = 1'b0;
        drive_slot();
        dma_wr_cyc = 1'b1;
        dma_wr_stb = 1'b1;
        dma_wr_adr = adr;
        dma_wr_dat = dat;
        dma_wr_sel = sel;
        while (!done) begin
            @(negedge clk);
            if (dma_wr_ack !== host_wr_ack)
                report_mismatch($sformatf("dma_wr_ack %b host_wr_ack %b",
                                          dma_wr_ack, host_wr_ack));
            done = dma_wr_ack;
        end
        drive_slot();
        dma_wr_cyc = 1'b0;
        dma_wr_stb = 1'b0;
        if (wr_adr_q.size() != n_before + 1)
            report_mismatch($sformatf("%0d host writes for one DMA write",
                                      wr_adr_q.size() - n_before));
        else if (wr_adr_q[n_before] !== asp_shell_pkg::host_line_addr_t'(adr >> 6)
                 || wr_dat_q[n_before] !== dat || wr_sel_q[n_before] !== sel)
            report_mismatch($sformatf("host write line %h for byte address %h",
                                      wr_adr_q[n_before], adr));
    endtask

    task automatic wait_host_writes(input int count);
        while (wr_adr_q.size() < count) @(negedge clk);
    endtask

    task automatic check_notify(input int idx, input asp_shell_pkg::irq_vec_t exp_vec);
        if (wr_adr_q.size() != idx + 1)
            report_mismatch($sformatf("%0d notification writes, expected 1",
                                      wr_adr_q.size() - idx));
        else if (wr_adr_q[idx] !== asp_shell_pkg::IRQ_STATUS_LINE || wr_sel_q[idx] !== '1)
            report_mismatch($sformatf("notification to line %h sel %h", wr_adr_q[idx],
                                      wr_sel_q[idx]));
        else if (wr_dat_q[idx] !== asp_shell_pkg::host_data_t'(exp_vec))
            report_mismatch($sformatf("irq vector %h expected %h", wr_dat_q[idx][7:0], exp_vec));
    endtask

    task automatic irq_notify(input asp_shell_pkg::irq_vec_t held,
                              input asp_shell_pkg::irq_vec_t exp_vec);
        int n_before;
        test_count++;
        n_before = wr_adr_q.size();
        drive_slot();
        kernel_irq  = held[asp_shell_pkg::KERNEL_IRQ_BIT];
        dma_irq_h2f = held[asp_shell_pkg::DMA_H2F_IRQ_BIT];
        dma_irq_f2h = held[asp_shell_pkg::DMA_F2H_IRQ_BIT];
        wait_host_writes(n_before + 1);
        repeat (12) @(negedge clk);  // room for a stray second write
        check_notify(n_before, exp_vec);
    endtask

    task automatic fenced_notify;
        int n_before;
        test_count++;
        n_before = wr_adr_q.size();
        drive_slot();
        kernel_irq  = 1'b0;  // falling lines never notify
        dma_irq_h2f = 1'b0;
        dma_irq_f2h = 1'b0;
        repeat (8) @(negedge clk);
        drive_slot();
        dma_wr_fence = 1'b1;
        dma_irq_h2f  = 1'b1;
        repeat (20) @(negedge clk);
        if (wr_adr_q.size() != n_before)
            report_mismatch($sformatf("%0d host writes while fenced",
                                      wr_adr_q.size() - n_before));
        drive_slot();
        dma_wr_fence = 1'b0;
        wait_host_writes(n_before + 1);
        repeat (12) @(negedge clk);
        check_notify(n_before, 4'h2);
    endtask

    initial begin
        void'($urandom(32'h186a_7f40));
        clk          = 1'b0;
        reset        = 1'b1;
        mmio_cyc     = 1'b0;
        mmio_stb     = 1'b0;
        mmio_we      = 1'b0;
        mmio_adr     = '0;
        mmio_sel     = '0;
        mmio_dat_w   = '0;
        dma_wr_cyc   = 1'b0;
        dma_wr_stb   = 1'b0;
        dma_wr_adr   = '0;
        dma_wr_dat   = '0;
        dma_wr_sel   = '0;
        kernel_irq   = 1'b0;
        dma_irq_h2f  = 1'b0;
        dma_irq_f2h  = 1'b0;
        dma_wr_fence = 1'b0;
        repeat (8) @(posedge clk);
        #1 reset = 1'b0;

        check_reset_state();
        // kernel window with word bit 14 low
        mmio_access(1'b1, 15'h0123, 8'hFF, 64'h1122_3344_5566_7788);
        mmio_access(1'b1, 15'h0456, 8'hF0, 64'hCAFE_F00D_0000_0000);
        mmio_access(1'b0, 15'h3FFF, 8'h0F, '0);
        mmio_access(1'b0, 15'h0010, 8'hF0, '0);
        mmio_access(1'b0, 15'h0011, 8'hF8, '0);
        // DMA CSR window
        mmio_access(1'b1, 15'h4001, 8'hF0, 64'h0BAD_BEEF_1234_5678);
        mmio_access(1'b0, 15'h7ABC, 8'hFF, '0);
        mmio_access(1'b0, 15'h4000, 8'hF8, '0);
        dma_write(48'h0000_1234_5640, {16{32'hA5A5_0001}}, '1);
        dma_write(48'h7FFF_0000_00C7, {8{64'h0123_4567_89AB_CDEF}}, 64'h0000_FFFF_0000_00FF);
        irq_notify(4'b0001, 4'h1);
        irq_notify(4'b0011, 4'h3);
        irq_notify(4'b0111, 4'h7);
        fenced_notify();

        $display("tests: %0d, host writes: %0d, errors: %0d", test_count, wr_adr_q.size(),
                 error_count);
        if (error_count == 0)
            $display("sim passed");
        else
            $display("sim failed");
        $finish;
    end

endmodule : asp_host_shell_tb

`default_nettype wire
